// File: rtl/soc_macros.svh
// SRAM decode ignores address bits above 19 and the SRAM mirrors inside its 256 KiB window
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// ======================================================================
// Bus widths
// ======================================================================

`define SOC_W_ADDR          32
`define SOC_W_DATA          32
`define SOC_W_PADDR         16

// ======================================================================
// AHB address map
// ======================================================================

// Internal boot/stack SRAM lives at 0x80000..0xbffff
`define SOC_SRAM_BASE       32'h0008_0000
`define SOC_SRAM_MASK       32'h000c_0000
`define SOC_APB_BASE        32'h000c_0000
`define SOC_APB_MASK        32'h000c_0000

// Depth in 32-bit words where 2^11 words make 8 KiB
`define SOC_SRAM_DEPTH_LOG2 11

// APB slots are decoded on paddr[15:12]
`define SOC_APB_GPIO_BASE   16'h0000
`define SOC_APB_PWM_BASE    16'h1000
`define SOC_APB_TBIO_BASE   16'hf000
`define SOC_APB_SLOT_MASK   16'hf000

`define SOC_N_PADS          11
`define SOC_W_PWM           8

`endif

// File: rtl/soc_pkg.sv
// Bus structs for a single AHB-Lite master without hburst or hprot, APB has no pprot or pstrb
`include "soc_macros.svh"

package soc_pkg;

typedef logic [`SOC_W_DATA-1:0] word_t;
typedef logic [`SOC_N_PADS-1:0] pad_vec_t;

typedef enum logic [1:0] {
	IDLE   = 2'b00,
	BUSY   = 2'b01,
	NONSEQ = 2'b10,
	SEQ    = 2'b11
} htrans_e;

// Address-phase signals of one AHB-Lite transfer
typedef struct packed {
	logic [`SOC_W_ADDR-1:0] haddr;
	logic                   hwrite;
	htrans_e                htrans;
	logic [2:0]             hsize;
} ahb_addr_t;

typedef struct packed {
	logic  hready_resp;
	logic  hresp;
	word_t hrdata;
} ahb_resp_t;

typedef struct packed {
	logic [`SOC_W_PADDR-1:0] paddr;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	word_t                   pwdata;
} apb_req_t;

typedef struct packed {
	word_t prdata;
	logic  pready;
	logic  pslverr;
} apb_resp_t;

// Data-phase owner in the AHB splitter
typedef enum logic [1:0] {SLOT_DEFAULT, SLOT_SRAM, SLOT_BRIDGE} ahb_slot_e;

// Bridge sequencing where the access cycle that sees pslverr is the first error cycle
typedef enum logic [1:0] {BR_IDLE, BR_SETUP, BR_ACCESS, BR_ERR} bridge_state_e;

endpackage

// File: rtl/ahbl_splitter.sv
// Single master only, unmapped addresses read zero, drop writes and never return an error
`include "soc_macros.svh"

module ahbl_splitter
	import soc_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,

	input  ahb_addr_t src_addr,
	output ahb_resp_t src_resp,

	output ahb_addr_t dst_addr_sram,
	output ahb_addr_t dst_addr_bridge,
	output logic      dst_hready,
	input  ahb_resp_t dst_resp_sram,
	input  ahb_resp_t dst_resp_bridge
);

logic      hit_sram;
logic      hit_bridge;
logic      addr_valid;
ahb_slot_e slot_d;
ahb_slot_e slot_q;

// ======================================================================
// Address phase
// ======================================================================

assign hit_sram   = (src_addr.haddr & `SOC_SRAM_MASK) == `SOC_SRAM_BASE;
assign hit_bridge = (src_addr.haddr & `SOC_APB_MASK) == `SOC_APB_BASE;

// With one master the muxed response is the bus-wide hready
assign dst_hready = src_resp.hready_resp;
assign addr_valid = dst_hready && (src_addr.htrans == NONSEQ || src_addr.htrans == SEQ);

always_comb begin
	dst_addr_sram   = src_addr;
	dst_addr_bridge = src_addr;
	// A slave that is not addressed only ever sees IDLE
	if (!hit_sram)
		dst_addr_sram.htrans = IDLE;
	if (!hit_bridge)
		dst_addr_bridge.htrans = IDLE;
end

always_comb begin
	if (addr_valid && hit_sram)
		slot_d = SLOT_SRAM;
	else if (addr_valid && hit_bridge)
		slot_d = SLOT_BRIDGE;
	else
		slot_d = SLOT_DEFAULT;
end

// ======================================================================
// Data phase
// ======================================================================

always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		slot_q <= SLOT_DEFAULT;
	end else if (dst_hready) begin
		slot_q <= slot_d;
	end
end

always_comb begin
	case (slot_q)
		SLOT_SRAM:   src_resp = dst_resp_sram;
		SLOT_BRIDGE: src_resp = dst_resp_bridge;
		default: begin
			src_resp.hready_resp = 1'b1;
			src_resp.hresp       = 1'b0;
			src_resp.hrdata      = '0;
		end
	endcase
end

endmodule

// File: rtl/ahb_sync_sram.sv
// Always zero-wait and OKAY, only word index bits DEPTH_LOG2+1..2 of haddr are decoded
`include "soc_macros.svh"

module ahb_sync_sram
	import soc_pkg::*;
#(
	parameter int DEPTH_LOG2 = `SOC_SRAM_DEPTH_LOG2
) (
	input  logic      clk_sys,
	input  logic      rst_n,

	input  ahb_addr_t ahbls_addr,
	input  logic      ahbls_hready,
	input  word_t     ahbls_hwdata,
	output ahb_resp_t ahbls_resp
);

localparam int DEPTH = 1 << DEPTH_LOG2;

word_t                 mem [DEPTH];
logic                  addr_valid;
logic [DEPTH_LOG2-1:0] addr_idx;
logic                  wr_pend;
logic [DEPTH_LOG2-1:0] wr_idx;
logic [3:0]            wr_mask;
word_t                 rd_raw;
logic [3:0]            fwd_mask;
word_t                 fwd_data;

// Byte lanes touched by a transfer of the given size and alignment
function automatic logic [3:0] lane_mask(input logic [2:0] hsize, input logic [1:0] lsb);
	logic [3:0] m;
	case (hsize)
		3'd0:    m = 4'b0001 << lsb;
		3'd1:    m = lsb[1] ? 4'b1100 : 4'b0011;
		default: m = 4'b1111;
	endcase
	return m;
endfunction

assign addr_valid = ahbls_hready
	&& (ahbls_addr.htrans == NONSEQ || ahbls_addr.htrans == SEQ);
assign addr_idx = ahbls_addr.haddr[DEPTH_LOG2+1:2];

// ======================================================================
// Write path
// ======================================================================

always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		wr_pend <= 1'b0;
	end else if (ahbls_hready) begin
		wr_pend <= addr_valid && ahbls_addr.hwrite;
	end
end

always_ff @(posedge clk_sys) begin
	if (addr_valid && ahbls_addr.hwrite) begin
		wr_idx  <= addr_idx;
		wr_mask <= lane_mask(ahbls_addr.hsize, ahbls_addr.haddr[1:0]);
	end
end

// hwdata is only valid in the data phase, so the array is written as it ends
always_ff @(posedge clk_sys) begin
	if (wr_pend && ahbls_hready) begin
		for (int i = 0; i < 4; i++) begin
			if (wr_mask[i])
				mem[wr_idx][8*i +: 8] <= ahbls_hwdata[8*i +: 8];
		end
	end
end

// ======================================================================
// Read path
// ======================================================================

// A read issued while the previous write lands still sees the old array
// contents, so the lanes being written are carried alongside
always_ff @(posedge clk_sys) begin
	if (addr_valid && !ahbls_addr.hwrite) begin
		rd_raw   <= mem[addr_idx];
		fwd_mask <= (wr_pend && wr_idx == addr_idx) ? wr_mask : 4'h0;
		fwd_data <= ahbls_hwdata;
	end
end

always_comb begin
	ahbls_resp.hready_resp = 1'b1;
	ahbls_resp.hresp       = 1'b0;
	for (int i = 0; i < 4; i++) begin
		ahbls_resp.hrdata[8*i +: 8] = fwd_mask[i] ? fwd_data[8*i +: 8] : rd_raw[8*i +: 8];
	end
end

endmodule

// File: rtl/ahbl_to_apb.sv
// One APB transfer at a time, pwdata is taken from hwdata in setup and paddr keeps the low 16 bits
`include "soc_macros.svh"

module ahbl_to_apb
	import soc_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,

	input  ahb_addr_t ahbls_addr,
	input  logic      ahbls_hready,
	input  word_t     ahbls_hwdata,
	output ahb_resp_t ahbls_resp,

	output apb_req_t  apbm_req,
	input  apb_resp_t apbm_resp
);

bridge_state_e           state;
bridge_state_e           state_nxt;
logic                    addr_valid;
logic [`SOC_W_PADDR-1:0] paddr_q;
logic                    pwrite_q;
word_t                   pwdata_q;

assign addr_valid = ahbls_hready
	&& (ahbls_addr.htrans == NONSEQ || ahbls_addr.htrans == SEQ);

// ======================================================================
// Sequencing
// ======================================================================

always_comb begin
	state_nxt = state;
	case (state)
		BR_IDLE: begin
			if (addr_valid)
				state_nxt = BR_SETUP;
		end
		BR_SETUP: begin
			state_nxt = BR_ACCESS;
		end
		BR_ACCESS: begin
			if (apbm_resp.pready) begin
				if (apbm_resp.pslverr)
					state_nxt = BR_ERR;
				else
					state_nxt = addr_valid ? BR_SETUP : BR_IDLE;
			end
		end
		default: begin
			state_nxt = addr_valid ? BR_SETUP : BR_IDLE;
		end
	endcase
end

always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		state <= BR_IDLE;
	end else begin
		state <= state_nxt;
	end
end

always_ff @(posedge clk_sys) begin
	if (addr_valid) begin
		paddr_q  <= ahbls_addr.haddr[`SOC_W_PADDR-1:0];
		pwrite_q <= ahbls_addr.hwrite;
	end
	if (state == BR_SETUP)
		pwdata_q <= ahbls_hwdata;
end

// ======================================================================
// Outputs
// ======================================================================

always_comb begin
	apbm_req.paddr   = paddr_q;
	apbm_req.psel    = state == BR_SETUP || state == BR_ACCESS;
	apbm_req.penable = state == BR_ACCESS;
	apbm_req.pwrite  = pwrite_q;
	// The master holds hwdata for the whole data phase, setup uses it directly
	apbm_req.pwdata  = state == BR_SETUP ? ahbls_hwdata : pwdata_q;

	ahbls_resp.hrdata = apbm_resp.prdata;
	case (state)
		BR_SETUP: begin
			ahbls_resp.hready_resp = 1'b0;
			ahbls_resp.hresp       = 1'b0;
		end
		BR_ACCESS: begin
			ahbls_resp.hready_resp = apbm_resp.pready && !apbm_resp.pslverr;
			ahbls_resp.hresp       = apbm_resp.pready && apbm_resp.pslverr;
		end
		BR_ERR: begin
			ahbls_resp.hready_resp = 1'b1;
			ahbls_resp.hresp       = 1'b1;
		end
		default: begin
			ahbls_resp.hready_resp = 1'b1;
			ahbls_resp.hresp       = 1'b0;
		end
	endcase
end

endmodule

// File: rtl/apb_splitter.sv
// Slots are 4 KiB on paddr[15:12], unused slots answer at once with zero data and no error
`include "soc_macros.svh"

module apb_splitter
	import soc_pkg::*;
(
	input  apb_req_t  apbs_req,
	output apb_resp_t apbs_resp,

	output apb_req_t  gpio_req,
	input  apb_resp_t gpio_resp,
	output apb_req_t  pwm_req,
	input  apb_resp_t pwm_resp,
	output apb_req_t  tbio_req,
	input  apb_resp_t tbio_resp
);

localparam apb_resp_t STUB_RESP = '{prdata: '0, pready: 1'b1, pslverr: 1'b0};

logic hit_gpio;
logic hit_pwm;
logic hit_tbio;

assign hit_gpio = (apbs_req.paddr & `SOC_APB_SLOT_MASK) == `SOC_APB_GPIO_BASE;
assign hit_pwm  = (apbs_req.paddr & `SOC_APB_SLOT_MASK) == `SOC_APB_PWM_BASE;
assign hit_tbio = (apbs_req.paddr & `SOC_APB_SLOT_MASK) == `SOC_APB_TBIO_BASE;

always_comb begin
	// Address keeps its slot bits, each slave decodes only its offset
	gpio_req      = apbs_req;
	gpio_req.psel = apbs_req.psel && hit_gpio;
	pwm_req       = apbs_req;
	pwm_req.psel  = apbs_req.psel && hit_pwm;
	tbio_req      = apbs_req;
	tbio_req.psel = apbs_req.psel && hit_tbio;

	if (hit_gpio)
		apbs_resp = gpio_resp;
	else if (hit_pwm)
		apbs_resp = pwm_resp;
	else if (hit_tbio)
		apbs_resp = tbio_resp;
	else
		apbs_resp = STUB_RESP;
end

endmodule

// File: rtl/gpio.sv
// padin is asynchronous and reaches the IN register after two flops, pads reset as inputs driving zero
`include "soc_macros.svh"

module gpio
	import soc_pkg::*;
#(
	parameter int N_PADS = `SOC_N_PADS
) (
	input  logic              clk_sys,
	input  logic              rst_n,

	input  apb_req_t          apbs_req,
	output apb_resp_t         apbs_resp,

	output logic [N_PADS-1:0] padout,
	output logic [N_PADS-1:0] padoe,
	input  logic [N_PADS-1:0] padin
);

localparam logic [11:0] REG_OUT = 12'h000;
localparam logic [11:0] REG_OE  = 12'h004;
localparam logic [11:0] REG_IN  = 12'h008;

logic [N_PADS-1:0] out_q;
logic [N_PADS-1:0] oe_q;
logic [N_PADS-1:0] in_meta;
logic [N_PADS-1:0] in_sync;
logic [11:0]       offs;
logic              wr_en;

assign offs  = apbs_req.paddr[11:0];
assign wr_en = apbs_req.psel && apbs_req.penable && apbs_req.pwrite;

always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		out_q   <= '0;
		oe_q    <= '0;
		in_meta <= '0;
		in_sync <= '0;
	end else begin
		in_meta <= padin;
		in_sync <= in_meta;
		if (wr_en && offs == REG_OUT)
			out_q <= apbs_req.pwdata[N_PADS-1:0];
		if (wr_en && offs == REG_OE)
			oe_q <= apbs_req.pwdata[N_PADS-1:0];
	end
end

assign padout = out_q;
assign padoe  = oe_q;

always_comb begin
	apbs_resp.pready  = 1'b1;
	apbs_resp.pslverr = 1'b0;
	case (offs)
		REG_OUT: apbs_resp.prdata = {{(`SOC_W_DATA-N_PADS){1'b0}}, out_q};
		REG_OE:  apbs_resp.prdata = {{(`SOC_W_DATA-N_PADS){1'b0}}, oe_q};
		REG_IN:  apbs_resp.prdata = {{(`SOC_W_DATA-N_PADS){1'b0}}, in_sync};
		default: apbs_resp.prdata = '0;
	endcase
end

endmodule

// File: rtl/pwm_tiny.sv
// Free-running 8-bit PWM with a period of 256 clocks and no prescaler, output idles at the invert level
`include "soc_macros.svh"

module pwm_tiny
	import soc_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,

	input  apb_req_t  apbs_req,
	output apb_resp_t apbs_resp,

	output logic      lcd_pwm
);

localparam int          W_PWM    = `SOC_W_PWM;
localparam logic [11:0] REG_CTRL = 12'h000;
localparam logic [11:0] REG_CMP  = 12'h004;

logic             en_q;
logic             inv_q;
logic [W_PWM-1:0] cmp_q;
logic [W_PWM-1:0] ctr_q;
logic [11:0]      offs;
logic             wr_en;

assign offs  = apbs_req.paddr[11:0];
assign wr_en = apbs_req.psel && apbs_req.penable && apbs_req.pwrite;

always_ff @(posedge clk_sys or negedge rst_n) begin
	if (!rst_n) begin
		en_q  <= 1'b0;
		inv_q <= 1'b0;
		cmp_q <= '0;
		ctr_q <= '0;
	end else begin
		ctr_q <= en_q ? ctr_q + 1'b1 : '0;
		if (wr_en && offs == REG_CTRL) begin
			en_q  <= apbs_req.pwdata[0];
			inv_q <= apbs_req.pwdata[1];
		end
		if (wr_en && offs == REG_CMP)
			cmp_q <= apbs_req.pwdata[W_PWM-1:0];
	end
end

// High for cmp_q counts of every 256 while running
assign lcd_pwm = en_q ? (ctr_q < cmp_q) ^ inv_q : inv_q;

always_comb begin
	apbs_resp.pready  = 1'b1;
	apbs_resp.pslverr = 1'b0;
	case (offs)
		REG_CTRL: apbs_resp.prdata = {{(`SOC_W_DATA-2){1'b0}}, inv_q, en_q};
		REG_CMP:  apbs_resp.prdata = {{(`SOC_W_DATA-W_PWM){1'b0}}, cmp_q};
		default:  apbs_resp.prdata = '0;
	endcase
end

endmodule

// File: rtl/soc_core.sv
// System core without a processor, the AHB-Lite port must come from a single master
`include "soc_macros.svh"

module soc_core
	import soc_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,

	input  ahb_addr_t src_addr,
	input  word_t     src_hwdata,
	output ahb_resp_t src_resp,

	input  pad_vec_t  padin,
	output pad_vec_t  padout,
	output pad_vec_t  padoe,
	output logic      lcd_pwm,

	output apb_req_t  tbio_req,
	input  apb_resp_t tbio_resp
);

ahb_addr_t sram_addr;
ahb_resp_t sram_resp;
ahb_addr_t bridge_addr;
ahb_resp_t bridge_resp;
logic      bus_hready;
apb_req_t  bridge_req;
apb_resp_t bridge_presp;
apb_req_t  gpio_req;
apb_resp_t gpio_resp;
apb_req_t  pwm_req;
apb_resp_t pwm_resp;

// ======================================================================
// Bus fabric
// ======================================================================

ahbl_splitter ahbl_splitter_i (
	.clk_sys         (clk_sys),
	.rst_n           (rst_n),
	.src_addr        (src_addr),
	.src_resp        (src_resp),
	.dst_addr_sram   (sram_addr),
	.dst_addr_bridge (bridge_addr),
	.dst_hready      (bus_hready),
	.dst_resp_sram   (sram_resp),
	.dst_resp_bridge (bridge_resp)
);

ahbl_to_apb bridge_i (
	.clk_sys      (clk_sys),
	.rst_n        (rst_n),
	.ahbls_addr   (bridge_addr),
	.ahbls_hready (bus_hready),
	.ahbls_hwdata (src_hwdata),
	.ahbls_resp   (bridge_resp),
	.apbm_req     (bridge_req),
	.apbm_resp    (bridge_presp)
);

apb_splitter apb_splitter_i (
	.apbs_req  (bridge_req),
	.apbs_resp (bridge_presp),
	.gpio_req  (gpio_req),
	.gpio_resp (gpio_resp),
	.pwm_req   (pwm_req),
	.pwm_resp  (pwm_resp),
	.tbio_req  (tbio_req),
	.tbio_resp (tbio_resp)
);

// ======================================================================
// Slaves
// ======================================================================

// Boot code and stack
ahb_sync_sram #(
	.DEPTH_LOG2 (`SOC_SRAM_DEPTH_LOG2)
) sram_i (
	.clk_sys      (clk_sys),
	.rst_n        (rst_n),
	.ahbls_addr   (sram_addr),
	.ahbls_hready (bus_hready),
	.ahbls_hwdata (src_hwdata),
	.ahbls_resp   (sram_resp)
);

gpio #(
	.N_PADS (`SOC_N_PADS)
) gpio_i (
	.clk_sys   (clk_sys),
	.rst_n     (rst_n),
	.apbs_req  (gpio_req),
	.apbs_resp (gpio_resp),
	.padout    (padout),
	.padoe     (padoe),
	.padin     (padin)
);

pwm_tiny pwm_i (
	.clk_sys   (clk_sys),
	.rst_n     (rst_n),
	.apbs_req  (pwm_req),
	.apbs_resp (pwm_resp),
	.lcd_pwm   (lcd_pwm)
);

endmodule

// File: verif/soc_core_tb.sv
// Directed tests for one AHB-Lite master, transfers never overlap except the SRAM write-then-read case
`include "soc_macros.svh"

module soc_core_tb
	import soc_pkg::*;
;

localparam int        WAIT_LIMIT = 64;
localparam ahb_addr_t IDLE_ADDR  = '{haddr: '0, hwrite: 1'b0, htrans: IDLE, hsize: 3'd2};
localparam logic [31:0] APB_BASE = `SOC_APB_BASE;

logic      clk_sys;
logic      rst_n;
ahb_addr_t src_addr;
word_t     src_hwdata;
ahb_resp_t src_resp;
pad_vec_t  padin;
pad_vec_t  padout;
pad_vec_t  padoe;
logic      lcd_pwm;
apb_req_t  tbio_req;
apb_resp_t tbio_resp;

integer seed;
integer error_count;
integer check_count_total;
integer tests_run;
integer tests_failed;
integer errors_before;
string  cur_test;
integer last_cycles;
logic   last_hresp;
word_t  sram_model [2**`SOC_SRAM_DEPTH_LOG2];

// External slot responder settings and log
integer                  tb_waits;
logic                    tb_err;
word_t                   tb_rdata;
integer                  wait_left;
logic [`SOC_W_PADDR-1:0] last_paddr;
logic                    last_pwrite;
word_t                   last_pwdata;

soc_core soc_core_i (
	.clk_sys    (clk_sys),
	.rst_n      (rst_n),
	.src_addr   (src_addr),
	.src_hwdata (src_hwdata),
	.src_resp   (src_resp),
	.padin      (padin),
	.padout     (padout),
	.padoe      (padoe),
	.lcd_pwm    (lcd_pwm),
	.tbio_req   (tbio_req),
	.tbio_resp  (tbio_resp)
);

always #5 clk_sys = ~clk_sys;

// ======================================================================
// External APB responder
// ======================================================================

// The setup cycle loads the wait count and pready rises after tb_waits low access cycles
always @(posedge clk_sys) begin
	if (tbio_req.psel && !tbio_req.penable) begin
		wait_left         <= tb_waits;
		tbio_resp.pready  <= (tb_waits == 0);
		tbio_resp.pslverr <= (tb_waits == 0) && tb_err;
		tbio_resp.prdata  <= (tb_waits == 0) ? tb_rdata : '0;
		last_paddr        <= tbio_req.paddr;
		last_pwrite       <= tbio_req.pwrite;
		last_pwdata       <= tbio_req.pwdata;
	end else if (tbio_req.psel && tbio_req.penable && !tbio_resp.pready) begin
		wait_left <= wait_left - 1;
		if (wait_left == 1) begin
			tbio_resp.pready  <= 1'b1;
			tbio_resp.pslverr <= tb_err;
			tbio_resp.prdata  <= tb_rdata;
		end
	end else begin
		tbio_resp <= '0;
	end
end

// ======================================================================
// Checks and reporting
// ======================================================================

task automatic check_word(input string what, input word_t exp, input word_t act);
	check_count_total++;
	if (exp !== act) begin
		$display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
		error_count++;
	end
endtask

task automatic check_resp(input string what, input logic exp, input logic act);
	check_count_total++;
	if (exp !== act) begin
		$display("error %s %s: expected hresp %b, actual %b", cur_test, what, exp, act);
		error_count++;
	end
endtask

task automatic check_pads(input string what, input pad_vec_t exp, input pad_vec_t act);
	check_count_total++;
	if (exp !== act) begin
		$display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
		error_count++;
	end
endtask

task automatic check_count(input string what, input integer exp, input integer act);
	check_count_total++;
	if (exp !== act) begin
		$display("error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		error_count++;
	end
endtask

task automatic begin_test(input string name);
	cur_test      = name;
	errors_before = error_count;
endtask

task automatic end_test();
	tests_run++;
	if (error_count > errors_before) begin
		tests_failed++;
		$display("test %s: FAIL with %0d errors", cur_test, error_count - errors_before);
	end else begin
		$display("test %s: ok", cur_test);
	end
endtask

// ======================================================================
// Bus driver
// ======================================================================

// Samples hready at falling edges until it is high, counting the cycles
task automatic wait_ready(input string what, output integer cycles);
	integer n;
	n = 0;
	@(negedge clk_sys);
	while (!src_resp.hready_resp && n < WAIT_LIMIT) begin
		n++;
		@(negedge clk_sys);
	end
	cycles = n + 1;
	if (!src_resp.hready_resp) begin
		$display("test %s: hready stayed low for %0d cycles in the %s", cur_test, n, what);
		error_count++;
	end
endtask

task automatic ahb_write(input logic [31:0] addr, input logic [2:0] size, input word_t data);
	integer cyc;
	@(posedge clk_sys);
	src_addr <= '{haddr: addr, hwrite: 1'b1, htrans: NONSEQ, hsize: size};
	wait_ready("write address phase", cyc);
	@(posedge clk_sys);
	src_addr   <= IDLE_ADDR;
	src_hwdata <= data;
	wait_ready("write data phase", cyc);
	last_cycles = cyc;
	last_hresp  = src_resp.hresp;
endtask

task automatic ahb_read(input logic [31:0] addr, output word_t data);
	integer cyc;
	@(posedge clk_sys);
	src_addr <= '{haddr: addr, hwrite: 1'b0, htrans: NONSEQ, hsize: 3'd2};
	wait_ready("read address phase", cyc);
	@(posedge clk_sys);
	src_addr <= IDLE_ADDR;
	wait_ready("read data phase", cyc);
	last_cycles = cyc;
	last_hresp  = src_resp.hresp;
	data        = src_resp.hrdata;
endtask

// Word write whose data phase overlaps the address phase of a read of the same word
task automatic write_read_back(input logic [31:0] addr, input word_t data, output word_t rd);
	integer cyc;
	@(posedge clk_sys);
	src_addr <= '{haddr: addr, hwrite: 1'b1, htrans: NONSEQ, hsize: 3'd2};
	wait_ready("write address phase", cyc);
	@(posedge clk_sys);
	src_addr   <= '{haddr: addr, hwrite: 1'b0, htrans: NONSEQ, hsize: 3'd2};
	src_hwdata <= data;
	wait_ready("write data phase", cyc);
	@(posedge clk_sys);
	src_addr <= IDLE_ADDR;
	wait_ready("read data phase", cyc);
	rd = src_resp.hrdata;
endtask

function automatic word_t merge_lanes(input word_t old, input word_t wr, input logic [3:0] lanes);
	word_t m;
	m = old;
	for (int i = 0; i < 4; i++) begin
		if (lanes[i])
			m[8*i +: 8] = wr[8*i +: 8];
	end
	return m;
endfunction

// ======================================================================
// Directed tests
// ======================================================================

task automatic reset_values();
	begin_test("reset");
	check_count("hready_resp", 1, src_resp.hready_resp);
	check_resp("hresp", 1'b0, src_resp.hresp);
	check_count("tbio psel", 0, tbio_req.psel);
	check_pads("padout", '0, padout);
	check_pads("padoe", '0, padoe);
	check_count("lcd_pwm", 0, lcd_pwm);
	end_test();
endtask

task automatic sram_access();
	int          idx_list[$];
	integer      idx;
	word_t       d;
	word_t       rd;
	word_t       exp;
	logic [31:0] a;
	begin_test("sram");
	for (int i = 0; i < 16; i++) begin
		idx = $random(seed) & 32'h7ff;
		d   = $random(seed);
		sram_model[idx] = d;
		idx_list.push_back(idx);
		ahb_write(`SOC_SRAM_BASE + idx * 4, 3'd2, d);
	end
	foreach (idx_list[i]) begin
		ahb_read(`SOC_SRAM_BASE + idx_list[i] * 4, rd);
		check_word("word read back", sram_model[idx_list[i]], rd);
		check_count("data phase cycles", 1, last_cycles);
	end
	// Byte in lane 1, then a halfword in lanes 3..2
	a   = `SOC_SRAM_BASE + 32'h100;
	exp = $random(seed);
	ahb_write(a, 3'd2, exp);
	d = $random(seed);
	ahb_write(a + 1, 3'd0, d);
	exp = merge_lanes(exp, d, 4'b0010);
	ahb_read(a, rd);
	check_word("byte write", exp, rd);
	d = $random(seed);
	ahb_write(a + 2, 3'd1, d);
	exp = merge_lanes(exp, d, 4'b1100);
	ahb_read(a, rd);
	check_word("halfword write", exp, rd);
	d = $random(seed);
	write_read_back(a + 32'h40, d, rd);
	check_word("read right after write", d, rd);
	end_test();
endtask

task automatic default_region();
	word_t keep;
	word_t rd;
	begin_test("default region");
	keep = $random(seed);
	ahb_write(`SOC_SRAM_BASE + 32'h40, 3'd2, keep);
	ahb_write(32'h0000_0040, 3'd2, ~keep);
	check_resp("write hresp", 1'b0, last_hresp);
	ahb_read(`SOC_SRAM_BASE + 32'h40, rd);
	check_word("mirrored SRAM word", keep, rd);
	ahb_read(32'h0000_0040, rd);
	check_word("read data", '0, rd);
	check_resp("read hresp", 1'b0, last_hresp);
	ahb_read(32'h0004_1234, rd);
	check_word("read data above SRAM", '0, rd);
	end_test();
endtask

task automatic gpio_pads();
	word_t    v;
	word_t    rd;
	pad_vec_t pin;
	begin_test("gpio");
	v = $random(seed);
	ahb_write(APB_BASE + 32'h0, 3'd2, v);
	check_count("data phase cycles", 2, last_cycles);
	ahb_read(APB_BASE + 32'h0, rd);
	check_pads("padout", pad_vec_t'(v), padout);
	check_word("OUT read back", word_t'(pad_vec_t'(v)), rd);
	v = $random(seed);
	ahb_write(APB_BASE + 32'h4, 3'd2, v);
	ahb_read(APB_BASE + 32'h4, rd);
	check_pads("padoe", pad_vec_t'(v), padoe);
	check_word("OE read back", word_t'(pad_vec_t'(v)), rd);
	pin = $random(seed);
	@(posedge clk_sys);
	padin <= pin;
	repeat (3) @(posedge clk_sys);
	ahb_read(APB_BASE + 32'h8, rd);
	check_word("IN read", word_t'(pin), rd);
	end_test();
endtask

task automatic count_high(output integer n);
	n = 0;
	repeat (2) @(posedge clk_sys);
	repeat (256) begin
		@(negedge clk_sys);
		if (lcd_pwm)
			n++;
	end
endtask

task automatic pwm_duty();
	integer c;
	integer n;
	begin_test("pwm");
	c = $random(seed) & 32'hff;
	ahb_write(APB_BASE + 32'h1004, 3'd2, c);
	ahb_write(APB_BASE + 32'h1000, 3'd2, 32'h1);
	count_high(n);
	check_count("high cycles", c, n);
	ahb_write(APB_BASE + 32'h1000, 3'd2, 32'h3);
	count_high(n);
	check_count("inverted high cycles", 256 - c, n);
	ahb_write(APB_BASE + 32'h1000, 3'd2, 32'h0);
	count_high(n);
	check_count("disabled high cycles", 0, n);
	end_test();
endtask

task automatic external_slot();
	word_t d;
	word_t rd;
	begin_test("external apb");
	tb_waits = 3;
	tb_err   = 1'b0;
	d        = $random(seed);
	ahb_write(APB_BASE + 32'hf024, 3'd2, d);
	check_count("write data phase cycles", 5, last_cycles);
	check_resp("write hresp", 1'b0, last_hresp);
	check_word("paddr", 32'hf024, word_t'(last_paddr));
	check_count("pwrite", 1, last_pwrite);
	check_word("pwdata", d, last_pwdata);
	tb_waits = 1;
	tb_rdata = $random(seed);
	ahb_read(APB_BASE + 32'hf008, rd);
	check_word("read data", tb_rdata, rd);
	check_count("read data phase cycles", 3, last_cycles);
	check_count("pwrite", 0, last_pwrite);
	// pslverr adds the second AHB error cycle
	tb_waits = 0;
	tb_err   = 1'b1;
	ahb_read(APB_BASE + 32'hf00c, rd);
	check_resp("error hresp", 1'b1, last_hresp);
	check_count("error data phase cycles", 3, last_cycles);
	tb_err = 1'b0;
	ahb_read(APB_BASE + 32'h3000, rd);
	check_word("empty slot data", '0, rd);
	check_resp("empty slot hresp", 1'b0, last_hresp);
	end_test();
endtask

initial begin
	seed              = 32'hf0e2_2f9f;
	error_count       = 0;
	check_count_total = 0;
	tests_run         = 0;
	tests_failed      = 0;
	clk_sys           = 1'b0;
	rst_n             = 1'b0;
	src_addr          = IDLE_ADDR;
	src_hwdata        = '0;
	padin             = '0;
	tbio_resp         = '0;
	tb_waits          = 0;
	tb_err            = 1'b0;
	tb_rdata          = '0;
	repeat (3) @(posedge clk_sys);
	rst_n <= 1'b1;
	@(negedge clk_sys);
	reset_values();
	sram_access();
	default_region();
	gpio_pads();
	pwm_duty();
	external_slot();
	$display("tests %0d, failed %0d, checks %0d, errors %0d",
		tests_run, tests_failed, check_count_total, error_count);
	if (error_count == 0)
		$display("sim passed");
	else
		$display("sim failed");
	$finish;
end

endmodule

// File: vlog.f
+incdir+rtl
rtl/soc_pkg.sv
rtl/ahbl_splitter.sv
rtl/ahb_sync_sram.sv
rtl/ahbl_to_apb.sv
rtl/apb_splitter.sv
rtl/gpio.sv
rtl/pwm_tiny.sv
rtl/soc_core.sv
verif/soc_core_tb.sv

// File: Bender.yml
package:
  name: soc_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/soc_pkg.sv
      - rtl/ahbl_splitter.sv
      - rtl/ahb_sync_sram.sv
      - rtl/ahbl_to_apb.sv
      - rtl/apb_splitter.sv
      - rtl/gpio.sv
      - rtl/pwm_tiny.sv
      - rtl/soc_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/soc_core_tb.sv
